// File: hw/leaf_pkt_pkg.sv
package leaf_pkt_pkg;

    localparam int PACKET_BITS   = 49;
    localparam int PAYLOAD_BITS  = 32;
    localparam int NUM_LEAF_BITS = 5;
    localparam int NUM_PORT_BITS = 4;
    localparam int NUM_SEQ_BITS  = 7;

    // Bit positions inside a packet on the BFT link
    localparam int VLD_POS       = 48;
    localparam int DEST_LEAF_LSB = 43;
    localparam int DEST_PORT_LSB = 39;
    localparam int SEQ_LSB       = 32;

    localparam logic [NUM_PORT_BITS-1:0] CFG_PORT = '0;  // Port 0 carries route-table writes

    // Fields inside the payload of a config packet
    localparam int CFG_OUT_LSB   = 0;
    localparam int CFG_LEAF_LSB  = 4;
    localparam int CFG_DPORT_LSB = 9;

    typedef logic [PAYLOAD_BITS-1:0] word_t;
    typedef logic [PACKET_BITS-1:0]  packet_t;

endpackage

// File: hw/leaf_cfg_pkg.sv
package leaf_cfg_pkg;

    localparam logic [4:0] LEAF_ID = 5'd3;

    localparam int NUM_IN_PORTS  = 5;
    localparam int NUM_OUT_PORTS = 5;
    localparam int PORT_IDX_BITS = $clog2(NUM_OUT_PORTS);

    localparam int FIFO_DEPTH = 8;

    localparam int START_DELAY    = 8;
    localparam int START_CNT_BITS = $clog2(START_DELAY + 1);

    typedef enum logic [1:0] {
        IDLE,
        START_WAIT,
        RUN
    } leaf_state_t;

endpackage

// File: hw/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 8
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     wr_en,
    input  payload_t wr_data,
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     empty,
    output logic     full
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    payload_t            mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                push;
    logic                pop;

    assign empty   = (count == '0);
    assign full    = (count == CNT_BITS'(DEPTH));
    assign push    = wr_en && !full;    // Writes into a full queue are dropped
    assign pop     = rd_en && !empty;
    assign rd_data = mem[rd_ptr];       // Oldest entry falls through to the output

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hw/start_delay_counter.sv
`timescale 1ns/1ps

module start_delay_counter (
    input  logic clk,
    input  logic rst,
    input  logic load,
    output logic done
);

    import leaf_cfg_pkg::*;

    logic [START_CNT_BITS-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            done  <= 1'b0;
        end else if (load) begin
            count <= START_CNT_BITS'(START_DELAY);
            done  <= 1'b0;
        end else begin
            done <= (count == START_CNT_BITS'(1));  // Single pulse as the count leaves one
            if (count != '0) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: hw/leaf_ctrl_fsm.sv
`timescale 1ns/1ps

module leaf_ctrl_fsm (
    input  logic clk,
    input  logic rst,
    input  logic ap_start,
    input  logic timer_done,
    output logic timer_load,
    output logic reset_ap_start_user
);

    import leaf_cfg_pkg::*;

    leaf_state_t state;
    leaf_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (ap_start) begin
                    state_nxt = START_WAIT;
                end
            end
            START_WAIT: begin
                if (timer_done) begin
                    state_nxt = RUN;
                end
            end
            RUN: begin
                state_nxt = RUN;    // Further start pulses are ignored
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // Counter is loaded on the same edge that enters START_WAIT
    assign timer_load = (state == IDLE) && ap_start;

    always_ff @(posedge clk) begin
        if (rst) begin
            state               <= IDLE;
            reset_ap_start_user <= 1'b1;
        end else begin
            state               <= state_nxt;
            reset_ap_start_user <= (state_nxt != RUN);  // Drops on the edge that enters RUN
        end
    end

endmodule

// File: hw/leaf_rx_demux.sv
`timescale 1ns/1ps

module leaf_rx_demux (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [leaf_pkt_pkg::PACKET_BITS-1:0]   din_leaf_bft2interface,
    input  logic [leaf_cfg_pkg::NUM_IN_PORTS-1:0]  rx_full,
    output logic [leaf_cfg_pkg::NUM_IN_PORTS-1:0]  rx_wr_en,
    output logic [leaf_pkt_pkg::PAYLOAD_BITS-1:0]  rx_wr_data,
    output logic                                   cfg_wr_en,
    output logic [leaf_pkt_pkg::NUM_PORT_BITS-1:0] cfg_out_idx,
    output logic [leaf_pkt_pkg::NUM_LEAF_BITS-1:0] cfg_leaf,
    output logic [leaf_pkt_pkg::NUM_PORT_BITS-1:0] cfg_dport
);

    import leaf_pkt_pkg::*;
    import leaf_cfg_pkg::*;

    packet_t                  pkt_q;
    logic                     pkt_vld_q;
    logic                     for_me;
    logic [NUM_PORT_BITS-1:0] dest_port;

    always_ff @(posedge clk) begin
        pkt_q <= din_leaf_bft2interface;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_vld_q <= 1'b0;
        end else begin
            pkt_vld_q <= din_leaf_bft2interface[VLD_POS];
        end
    end

    assign dest_port = pkt_q[DEST_PORT_LSB +: NUM_PORT_BITS];
    assign for_me    = pkt_vld_q && (pkt_q[DEST_LEAF_LSB +: NUM_LEAF_BITS] == LEAF_ID);

    // User ports are numbered from one, so queue i takes port i+1
    always_comb begin
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            rx_wr_en[i] = for_me && (dest_port == NUM_PORT_BITS'(i + 1)) && !rx_full[i];
        end
    end

    assign rx_wr_data = pkt_q[PAYLOAD_BITS-1:0];

    assign cfg_wr_en   = for_me && (dest_port == CFG_PORT);
    assign cfg_out_idx = pkt_q[CFG_OUT_LSB +: NUM_PORT_BITS];
    assign cfg_leaf    = pkt_q[CFG_LEAF_LSB +: NUM_LEAF_BITS];
    assign cfg_dport   = pkt_q[CFG_DPORT_LSB +: NUM_PORT_BITS];

endmodule

// File: hw/leaf_tx_arbiter.sv
`timescale 1ns/1ps

module leaf_tx_arbiter (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   resend,
    input  logic [leaf_cfg_pkg::NUM_OUT_PORTS-1:0] tx_empty,
    input  logic [leaf_cfg_pkg::NUM_OUT_PORTS-1:0][leaf_pkt_pkg::PAYLOAD_BITS-1:0] tx_data,
    input  logic                                   cfg_wr_en,
    input  logic [leaf_pkt_pkg::NUM_PORT_BITS-1:0] cfg_out_idx,
    input  logic [leaf_pkt_pkg::NUM_LEAF_BITS-1:0] cfg_leaf,
    input  logic [leaf_pkt_pkg::NUM_PORT_BITS-1:0] cfg_dport,
    output logic [leaf_cfg_pkg::NUM_OUT_PORTS-1:0] tx_rd_en,
    output logic [leaf_pkt_pkg::PACKET_BITS-1:0]   dout_leaf_interface2bft
);

    import leaf_pkt_pkg::*;
    import leaf_cfg_pkg::*;

    logic [NUM_LEAF_BITS-1:0] route_leaf [NUM_OUT_PORTS];
    logic [NUM_PORT_BITS-1:0] route_port [NUM_OUT_PORTS];
    logic [NUM_SEQ_BITS-1:0]  seq_cnt    [NUM_OUT_PORTS];
    logic [PORT_IDX_BITS-1:0] last_q;
    logic [PORT_IDX_BITS-1:0] grant_idx;
    logic [PORT_IDX_BITS-1:0] cfg_slot;
    logic                     grant_vld;
    logic                     cfg_hit;
    logic                     send;
    packet_t                  pkt_nxt;
    packet_t                  dout_q;

    // Search starts just after the port served last
    always_comb begin : rr_pick
        int unsigned cand;
        grant_vld = 1'b0;
        grant_idx = last_q;
        for (int k = 1; k <= NUM_OUT_PORTS; k++) begin
            cand = (int'(last_q) + k) % NUM_OUT_PORTS;
            if (!grant_vld && !tx_empty[cand]) begin
                grant_vld = 1'b1;
                grant_idx = PORT_IDX_BITS'(cand);
            end
        end
    end

    assign send = grant_vld && !resend;

    always_comb begin
        tx_rd_en = '0;
        if (send) begin
            tx_rd_en[grant_idx] = 1'b1;
        end
    end

    always_comb begin
        pkt_nxt                                  = '0;
        pkt_nxt[VLD_POS]                         = 1'b1;
        pkt_nxt[DEST_LEAF_LSB +: NUM_LEAF_BITS]  = route_leaf[grant_idx];
        pkt_nxt[DEST_PORT_LSB +: NUM_PORT_BITS]  = route_port[grant_idx];
        pkt_nxt[SEQ_LSB +: NUM_SEQ_BITS]         = seq_cnt[grant_idx];
        pkt_nxt[PAYLOAD_BITS-1:0]                = tx_data[grant_idx];
    end

    assign cfg_hit  = cfg_wr_en && (cfg_out_idx != '0) &&
                      (cfg_out_idx <= NUM_PORT_BITS'(NUM_OUT_PORTS));
    assign cfg_slot = PORT_IDX_BITS'(cfg_out_idx - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                route_leaf[i] <= '0;
                route_port[i] <= '0;
                seq_cnt[i]    <= '0;
            end
            last_q <= PORT_IDX_BITS'(NUM_OUT_PORTS - 1);  // Port 1 wins the first round
            dout_q <= '0;
        end else begin
            if (cfg_hit) begin
                route_leaf[cfg_slot] <= cfg_leaf;
                route_port[cfg_slot] <= cfg_dport;
            end
            if (send) begin
                seq_cnt[grant_idx] <= seq_cnt[grant_idx] + 1'b1;
                last_q             <= grant_idx;
            end
            if (!resend) begin
                dout_q <= send ? pkt_nxt : '0;
            end
        end
    end

    // A packet caught by resend is held and goes out once resend drops
    assign dout_leaf_interface2bft = resend ? '0 : dout_q;

endmodule

// File: hw/leaf_interface.sv
`timescale 1ns/1ps

module leaf_interface (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [leaf_pkt_pkg::PACKET_BITS-1:0]   din_leaf_bft2interface,
    input  logic                                   resend,
    input  logic                                   ap_start,
    input  logic [leaf_cfg_pkg::NUM_IN_PORTS-1:0]  ack_user2interface,
    input  logic [leaf_cfg_pkg::NUM_OUT_PORTS-1:0][leaf_pkt_pkg::PAYLOAD_BITS-1:0]
                                                   din_leaf_user2interface,
    input  logic [leaf_cfg_pkg::NUM_OUT_PORTS-1:0] vld_user2interface,
    output logic [leaf_pkt_pkg::PACKET_BITS-1:0]   dout_leaf_interface2bft,
    output logic [leaf_cfg_pkg::NUM_IN_PORTS-1:0][leaf_pkt_pkg::PAYLOAD_BITS-1:0]
                                                   dout_leaf_interface2user,
    output logic [leaf_cfg_pkg::NUM_IN_PORTS-1:0]  vld_interface2user,
    output logic [leaf_cfg_pkg::NUM_OUT_PORTS-1:0] ack_interface2user,
    output logic                                   reset_ap_start_user
);

    import leaf_pkt_pkg::*;
    import leaf_cfg_pkg::*;

    logic                     timer_load;
    logic                     timer_done;
    logic [NUM_IN_PORTS-1:0]  rx_wr_en;
    logic [NUM_IN_PORTS-1:0]  rx_full;
    logic [NUM_IN_PORTS-1:0]  rx_empty;
    word_t                    rx_wr_data;
    logic                     cfg_wr_en;
    logic [NUM_PORT_BITS-1:0] cfg_out_idx;
    logic [NUM_LEAF_BITS-1:0] cfg_leaf;
    logic [NUM_PORT_BITS-1:0] cfg_dport;
    logic [NUM_OUT_PORTS-1:0] tx_rd_en;
    logic [NUM_OUT_PORTS-1:0] tx_full;
    logic [NUM_OUT_PORTS-1:0] tx_empty;
    logic [NUM_OUT_PORTS-1:0][PAYLOAD_BITS-1:0] tx_data;

    assign vld_interface2user = ~rx_empty;
    assign ack_interface2user = ~tx_full;   // Full transmit queue is the only back-pressure

    leaf_ctrl_fsm ctrl_fsm_inst (
        .clk                 (clk),
        .rst                 (rst),
        .ap_start            (ap_start),
        .timer_done          (timer_done),
        .timer_load          (timer_load),
        .reset_ap_start_user (reset_ap_start_user)
    );

    start_delay_counter start_delay_inst (
        .clk  (clk),
        .rst  (rst),
        .load (timer_load),
        .done (timer_done)
    );

    leaf_rx_demux rx_demux_inst (
        .clk                    (clk),
        .rst                    (rst),
        .din_leaf_bft2interface (din_leaf_bft2interface),
        .rx_full                (rx_full),
        .rx_wr_en               (rx_wr_en),
        .rx_wr_data             (rx_wr_data),
        .cfg_wr_en              (cfg_wr_en),
        .cfg_out_idx            (cfg_out_idx),
        .cfg_leaf               (cfg_leaf),
        .cfg_dport              (cfg_dport)
    );

    leaf_tx_arbiter tx_arbiter_inst (
        .clk                     (clk),
        .rst                     (rst),
        .resend                  (resend),
        .tx_empty                (tx_empty),
        .tx_data                 (tx_data),
        .cfg_wr_en               (cfg_wr_en),
        .cfg_out_idx             (cfg_out_idx),
        .cfg_leaf                (cfg_leaf),
        .cfg_dport               (cfg_dport),
        .tx_rd_en                (tx_rd_en),
        .dout_leaf_interface2bft (dout_leaf_interface2bft)
    );

    for (genvar i = 0; i < NUM_IN_PORTS; i++) begin : g_rx
        stream_fifo #(
            .payload_t (word_t),
            .DEPTH     (FIFO_DEPTH)
        ) rx_fifo_inst (
            .clk     (clk),
            .rst     (rst),
            .wr_en   (rx_wr_en[i]),
            .wr_data (rx_wr_data),
            .rd_en   (ack_user2interface[i]),
            .rd_data (dout_leaf_interface2user[i]),
            .empty   (rx_empty[i]),
            .full    (rx_full[i])
        );
    end

    for (genvar i = 0; i < NUM_OUT_PORTS; i++) begin : g_tx
        stream_fifo #(
            .payload_t (word_t),
            .DEPTH     (FIFO_DEPTH)
        ) tx_fifo_inst (
            .clk     (clk),
            .rst     (rst),
            .wr_en   (vld_user2interface[i]),
            .wr_data (din_leaf_user2interface[i]),
            .rd_en   (tx_rd_en[i]),
            .rd_data (tx_data[i]),
            .empty   (tx_empty[i]),
            .full    (tx_full[i])
        );
    end

endmodule

// File: tb/leaf_interface_properties.sv
`timescale 1ns/1ps

module leaf_interface_properties (
    input logic                                  clk,
    input logic                                  rst,
    input logic                                  resend,
    input logic                                  timer_load,
    input logic [leaf_pkt_pkg::PACKET_BITS-1:0]  dout_leaf_interface2bft,
    input logic [leaf_cfg_pkg::NUM_IN_PORTS-1:0] vld_interface2user,
    input logic                                  reset_ap_start_user
);

    import leaf_pkt_pkg::*;
    import leaf_cfg_pkg::*;

    int unsigned fail_count = 0;    // Number of assertion failures so far

    // One edge after reset is sampled all registers hold their reset values
    quiet_in_reset: assert property (@(posedge clk)
        rst |=> !dout_leaf_interface2bft[VLD_POS] && (vld_interface2user == '0) &&
                reset_ap_start_user)
    else begin
        fail_count++;
        $error("Valid output or released user reset while rst was high");
    end

    muted_on_resend: assert property (@(posedge clk)
        resend |-> (dout_leaf_interface2bft == '0))
    else begin
        fail_count++;
        $error("Outgoing link not all zeros while resend was high");
    end

    // timer_load marks the edge that accepted ap_start
    start_release: assert property (@(posedge clk) disable iff (rst)
        timer_load |=> reset_ap_start_user [*START_DELAY+1] ##1 !reset_ap_start_user)
    else begin
        fail_count++;
        $error("User reset did not fall START_DELAY+1 edges after ap_start");
    end

endmodule

bind leaf_interface leaf_interface_properties props_inst (.*);

// File: tb/tb_leaf_interface.sv
`timescale 1ns/1ps

module tb_leaf_interface;

    import leaf_pkt_pkg::*;
    import leaf_cfg_pkg::*;

    localparam int TIMEOUT_CYCLES  = 4000;
    localparam int ROUTE_LEAF_BASE = 16;

    logic                                       clk = 1'b0;
    logic                                       rst;
    logic [PACKET_BITS-1:0]                     din_leaf_bft2interface;
    logic                                       resend;
    logic                                       ap_start;
    logic [NUM_IN_PORTS-1:0]                    ack_user2interface;
    logic [NUM_OUT_PORTS-1:0][PAYLOAD_BITS-1:0] din_leaf_user2interface;
    logic [NUM_OUT_PORTS-1:0]                   vld_user2interface;
    logic [PACKET_BITS-1:0]                     dout_leaf_interface2bft;
    logic [NUM_IN_PORTS-1:0][PAYLOAD_BITS-1:0]  dout_leaf_interface2user;
    logic [NUM_IN_PORTS-1:0]                    vld_interface2user;
    logic [NUM_OUT_PORTS-1:0]                   ack_interface2user;
    logic                                       reset_ap_start_user;

    logic [31:0]              rng_state = 32'hcf81_7e22;
    int unsigned              cycle_cnt = 0;
    word_t                    rx_exp [NUM_IN_PORTS][$];
    word_t                    tx_exp [NUM_OUT_PORTS][$];
    logic [NUM_SEQ_BITS-1:0]  seq_exp [NUM_OUT_PORTS];
    logic [NUM_LEAF_BITS-1:0] route_leaf [NUM_OUT_PORTS];
    logic [NUM_PORT_BITS-1:0] route_port [NUM_OUT_PORTS];
    logic                     rr_check = 1'b0;
    int                       prev_port = -1;

    leaf_interface UUT (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else
            fail_run($sformatf("FAILED at time %0t: %s expected %0h, actual %0h",
                               $time, name, exp, act));
    endtask

    task automatic send_packet(input logic [NUM_LEAF_BITS-1:0] leaf,
                               input logic [NUM_PORT_BITS-1:0] port,
                               input word_t payload, input logic vld);
        @(posedge clk);
        din_leaf_bft2interface <= {vld, leaf, port, NUM_SEQ_BITS'(0), payload};
        if (vld && leaf == LEAF_ID && port >= 1 && port <= NUM_IN_PORTS)
            rx_exp[int'(port) - 1].push_back(payload);
    endtask

    // Kernel side writer that holds a word until the queue accepts it
    task automatic write_words(input logic [NUM_OUT_PORTS-1:0] mask, input int count);
        int                       left [NUM_OUT_PORTS];
        logic [NUM_OUT_PORTS-1:0] vld_nxt;
        for (int i = 0; i < NUM_OUT_PORTS; i++)
            left[i] = mask[i] ? count : 0;
        do begin
            @(posedge clk);
            for (int i = 0; i < NUM_OUT_PORTS; i++) begin
                if (vld_user2interface[i] && ack_interface2user[i])
                    left[i]--;
                vld_nxt[i] = (left[i] > 0);
                if (vld_nxt[i] && !(vld_user2interface[i] && !ack_interface2user[i]))
                    din_leaf_user2interface[i] <= lcg_next();
            end
            vld_user2interface <= vld_nxt;
        end while (vld_nxt != '0);
    endtask

    task automatic wait_drain();
        int busy;
        do begin
            @(posedge clk);
            busy = 0;
            for (int i = 0; i < NUM_OUT_PORTS; i++)
                busy += rx_exp[i].size() + tx_exp[i].size();
        end while (busy != 0);
        repeat (2) @(posedge clk);
    endtask

    always @(posedge clk) begin : monitor
        int p;
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            fail_run("Timeout: the test did not finish within the cycle limit");
        assert (UUT.props_inst.fail_count == 0) else
            fail_run("A bound property on the DUT failed");
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            if (vld_interface2user[i] && ack_user2interface[i]) begin
                assert (rx_exp[i].size() > 0) else
                    fail_run($sformatf("Unexpected word on user input port %0d", i + 1));
                check_value($sformatf("dout_leaf_interface2user[%0d]", i),
                            rx_exp[i].pop_front(), dout_leaf_interface2user[i]);
            end
        end
        if (dout_leaf_interface2bft[VLD_POS]) begin
            p = int'(dout_leaf_interface2bft[DEST_LEAF_LSB +: NUM_LEAF_BITS]) - ROUTE_LEAF_BASE;
            assert (p >= 0 && p < NUM_OUT_PORTS && tx_exp[p].size() > 0) else
                fail_run("Output packet with an unknown route or without a written word");
            if (rr_check && prev_port >= 0)
                check_value("round-robin port", (prev_port + 1) % NUM_OUT_PORTS, p);
            check_value("dout_leaf_interface2bft",
                        {1'b1, route_leaf[p], route_port[p], seq_exp[p], tx_exp[p].pop_front()},
                        dout_leaf_interface2bft);
            seq_exp[p]++;
            prev_port = rr_check ? p : -1;
        end
        for (int i = 0; i < NUM_OUT_PORTS; i++)
            if (vld_user2interface[i] && ack_interface2user[i])
                tx_exp[i].push_back(din_leaf_user2interface[i]);
    end

    initial begin
        int                       n;
        logic [31:0]              r;
        logic [NUM_LEAF_BITS-1:0] leaf;
        rst = 1'b1;
        resend = 1'b0;
        ap_start = 1'b0;
        din_leaf_bft2interface = '0;
        ack_user2interface = '1;
        din_leaf_user2interface = '0;
        vld_user2interface = '0;
        for (int i = 0; i < NUM_OUT_PORTS; i++) begin
            seq_exp[i] = '0;
            route_leaf[i] = NUM_LEAF_BITS'(ROUTE_LEAF_BASE + i);
            route_port[i] = NUM_PORT_BITS'(i + 1);
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("reset_ap_start_user", 1, reset_ap_start_user);

        ap_start <= 1'b1;
        @(posedge clk);
        ap_start <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (reset_ap_start_user && n < 50);
        check_value("edges until user reset seen low", START_DELAY + 2, n);
        ap_start <= 1'b1;
        @(posedge clk);
        ap_start <= 1'b0;
        repeat (START_DELAY + 4) begin
            @(posedge clk);
            check_value("reset_ap_start_user", 0, reset_ap_start_user);
        end

        for (int k = 0; k < 40; k++) begin
            r = lcg_next();
            leaf = (r[2:0] == 3'd0) ? (LEAF_ID ^ (r[8:4] | 5'd1)) : LEAF_ID;
            send_packet(leaf, NUM_PORT_BITS'(1 + r[15:9] % 7), lcg_next(), r[20:19] != 2'd0);
        end
        send_packet('0, '0, '0, 1'b0);
        wait_drain();

        for (int i = 0; i < NUM_OUT_PORTS; i++)
            send_packet(LEAF_ID, CFG_PORT,
                        word_t'({route_port[i], route_leaf[i], NUM_PORT_BITS'(i + 1)}), 1'b1);
        send_packet(LEAF_ID ^ 5'd1, CFG_PORT, 32'h0000_1fe1, 1'b1);  // Meant for another leaf
        send_packet('0, '0, '0, 1'b0);
        repeat (3) @(posedge clk);
        write_words(5'b11111, 3);
        wait_drain();

        resend <= 1'b1;
        rr_check = 1'b1;
        write_words(5'b11111, 4);
        repeat (3) @(posedge clk);
        resend <= 1'b0;
        wait_drain();
        rr_check = 1'b0;

        fork
            write_words(5'b10101, 6);
            begin
                repeat (3) @(posedge clk);
                resend <= 1'b1;
                repeat (10) @(posedge clk);
                resend <= 1'b0;
            end
        join
        wait_drain();

        fork
            write_words(5'b00010, FIFO_DEPTH + 4);
            begin
                @(posedge clk);
                resend <= 1'b1;
                do begin
                    @(posedge clk);
                end while (ack_interface2user[1]);
                check_value("words accepted on port 2 before ack fell", FIFO_DEPTH,
                            tx_exp[1].size());
                repeat (3) @(posedge clk);
                check_value("ack_interface2user[1]", 0, ack_interface2user[1]);
                resend <= 1'b0;
            end
        join
        wait_drain();

        if (UUT.props_inst.fail_count != 0) begin
            $display("*** TEST FAILED ***");
            $fatal(1, "Bound property failures were counted");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// File: verilog.f
hw/leaf_pkt_pkg.sv
hw/leaf_cfg_pkg.sv
hw/stream_fifo.sv
hw/start_delay_counter.sv
hw/leaf_ctrl_fsm.sv
hw/leaf_rx_demux.sv
hw/leaf_tx_arbiter.sv
hw/leaf_interface.sv
tb/leaf_interface_properties.sv
tb/tb_leaf_interface.sv

// File: Bender.yml
package:
  name: leaf_interface

sources:
  - hw/leaf_pkt_pkg.sv
  - hw/leaf_cfg_pkg.sv
  - hw/stream_fifo.sv
  - hw/start_delay_counter.sv
  - hw/leaf_ctrl_fsm.sv
  - hw/leaf_rx_demux.sv
  - hw/leaf_tx_arbiter.sv
  - hw/leaf_interface.sv
  - target: test
    files:
      - tb/leaf_interface_properties.sv
      - tb/tb_leaf_interface.sv
